// ==== maze_pkg.sv ====
package maze_pkg;

    // ==============================
    // mesh geometry
    // ==============================
    localparam int MESH_DIM  = 8;   // nodes per side
    localparam int COORD_W   = 3;   // bits per coordinate
    localparam int NUM_PORTS = 5;

    // port indices shared by request, grant and data arrays
    localparam int PORT_LOCAL = 0;
    localparam int PORT_NORTH = 1;  // towards y+1
    localparam int PORT_SOUTH = 2;  // towards y-1
    localparam int PORT_EAST  = 3;  // towards x+1
    localparam int PORT_WEST  = 4;  // towards x-1

    // ==============================
    // packet types
    // ==============================

    // y in the upper bits and x in the lower bits
    typedef struct packed {
        logic [COORD_W-1:0] y;
        logic [COORD_W-1:0] x;
    } coord_t;

    // 23 bits on every external link
    typedef struct packed {
        logic       qos;     // high priority
        logic [1:0] ptype;   // carried but not decoded
        coord_t     src;
        coord_t     tgt;
        logic [7:0] data;
    } pkt_t;

    // one bit per port
    typedef logic [NUM_PORTS-1:0] port_vec_t;

    // packet plus its precomputed one-hot output port
    typedef struct packed {
        pkt_t      pkt;
        port_vec_t route;
    } routed_pkt_t;

endpackage

// ==== reg_slice.sv ====
`timescale 1ns/1ps

module reg_slice #(
    parameter type T = logic
) (
    input  logic clk,
    input  logic arst_n_i,
    // upstream side
    input  logic valid_i,
    output logic ready_o,
    input  T     data_i,
    // downstream side
    output logic valid_o,
    input  logic ready_i,
    output T     data_o
);

    logic full_q;
    T     data_q;

    // room when empty or when the held entry drains this cycle
    assign ready_o = ~full_q | ready_i;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            full_q <= 1'b0;
        end else if (ready_o) begin
            full_q <= valid_i;  // refill or go empty
        end
    end

    // payload register
    always_ff @(posedge clk) begin
        if (valid_i && ready_o) begin
            data_q <= data_i;
        end
    end

    assign valid_o = full_q;
    assign data_o  = data_q;

    // ==============================
    // checks
    // ==============================

    // a stalled entry keeps valid and payload until taken
    a_hold_stable: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        valid_o && !ready_i |=> valid_o && $stable(data_o)
    ) else $error("reg_slice: payload changed while stalled");

endmodule

// ==== input_port.sv ====
`timescale 1ns/1ps

module input_port #(
    parameter logic [maze_pkg::COORD_W-1:0] LOC_X = '0,
    parameter logic [maze_pkg::COORD_W-1:0] LOC_Y = '0
) (
    input  logic                clk,
    input  logic                arst_n_i,
    input  logic                valid_i,
    output logic                ready_o,
    input  maze_pkg::pkt_t      pkt_i,
    input  logic                pg_en_i,
    input  maze_pkg::coord_t    pg_node_i,
    output maze_pkg::port_vec_t req_o,
    output maze_pkg::pkt_t      head_o,
    input  logic                release_i
);

    maze_pkg::port_vec_t   xy_route;
    maze_pkg::port_vec_t   route;
    maze_pkg::coord_t      nbr;         // next node on the plain XY path
    logic                  horiz;       // XY hop is east or west
    logic                  detour;
    maze_pkg::routed_pkt_t rpkt_in;
    maze_pkg::routed_pkt_t rpkt_q;
    logic                  held_valid;

    // ==============================
    // dimension-order XY
    // ==============================
    always_comb begin
        xy_route = '0;
        nbr.x    = LOC_X;
        nbr.y    = LOC_Y;
        horiz    = 1'b0;
        if (pkt_i.tgt.x == LOC_X && pkt_i.tgt.y == LOC_Y) begin
            xy_route[maze_pkg::PORT_LOCAL] = 1'b1;
        end else if (pkt_i.tgt.x > LOC_X) begin
            xy_route[maze_pkg::PORT_EAST] = 1'b1;
            nbr.x = LOC_X + 3'd1;
            horiz = 1'b1;
        end else if (pkt_i.tgt.x < LOC_X) begin
            xy_route[maze_pkg::PORT_WEST] = 1'b1;
            nbr.x = LOC_X - 3'd1;
            horiz = 1'b1;
        end else if (pkt_i.tgt.y > LOC_Y) begin
            xy_route[maze_pkg::PORT_NORTH] = 1'b1;
            nbr.y = LOC_Y + 3'd1;
        end else begin
            xy_route[maze_pkg::PORT_SOUTH] = 1'b1;
            nbr.y = LOC_Y - 3'd1;
        end
    end

    // ==============================
    // detour around the faulty node
    // ==============================
    // a packet for the faulty node itself still goes straight
    assign detour = pg_en_i && !xy_route[maze_pkg::PORT_LOCAL]
                    && (nbr == pg_node_i) && (pkt_i.tgt != pg_node_i);

    always_comb begin
        route = xy_route;
        if (detour) begin
            route = '0;
            if (horiz) begin
                if (pkt_i.tgt.y > LOC_Y) begin
                    route[maze_pkg::PORT_NORTH] = 1'b1;
                end else if (pkt_i.tgt.y < LOC_Y) begin
                    route[maze_pkg::PORT_SOUTH] = 1'b1;
                end else if (LOC_Y == 3'(maze_pkg::MESH_DIM - 1)) begin
                    route[maze_pkg::PORT_SOUTH] = 1'b1;  // top row
                end else begin
                    route[maze_pkg::PORT_NORTH] = 1'b1;
                end
            end else if (LOC_X == 3'(maze_pkg::MESH_DIM - 1)) begin
                route[maze_pkg::PORT_WEST] = 1'b1;  // east edge so turn back
            end else begin
                route[maze_pkg::PORT_EAST] = 1'b1;
            end
        end
    end

    assign rpkt_in = '{pkt: pkt_i, route: route};

    reg_slice #(
        .T (maze_pkg::routed_pkt_t)
    ) u_slice (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .valid_i  (valid_i),
        .ready_o  (ready_o),
        .data_i   (rpkt_in),
        .valid_o  (held_valid),
        .ready_i  (release_i),
        .data_o   (rpkt_q)
    );

    assign req_o  = held_valid ? rpkt_q.route : '0;
    assign head_o = rpkt_q.pkt;

    a_req_onehot: assert property (
        @(posedge clk) disable iff (!arst_n_i) $onehot0(req_o)
    ) else $error("input_port: route not one-hot");

endmodule

// ==== qos_arbiter.sv ====
`timescale 1ns/1ps

module qos_arbiter (
    input  logic                clk,
    input  logic                arst_n_i,
    input  maze_pkg::port_vec_t req_i,
    input  maze_pkg::port_vec_t qos_i,
    input  logic                accept_i,
    output maze_pkg::port_vec_t gnt_o
);

    localparam int PTR_W = $clog2(maze_pkg::NUM_PORTS);

    logic [PTR_W-1:0]    ptr_q;     // first index to look at
    logic [PTR_W-1:0]    win_idx;
    maze_pkg::port_vec_t hi_req;
    maze_pkg::port_vec_t cand;
    logic                found;
    int                  idx;

    // qos filter
    assign hi_req = req_i & qos_i;
    assign cand   = (|hi_req) ? hi_req : req_i;

    // ==============================
    // round robin from ptr_q
    // ==============================
    always_comb begin
        gnt_o   = '0;
        win_idx = '0;
        found   = 1'b0;
        idx     = 0;
        for (int k = 0; k < maze_pkg::NUM_PORTS; k++) begin
            idx = int'(ptr_q) + k;
            if (idx >= maze_pkg::NUM_PORTS) begin
                idx = idx - maze_pkg::NUM_PORTS;  // wrap
            end
            if (!found && cand[idx]) begin
                found      = 1'b1;
                gnt_o[idx] = 1'b1;
                win_idx    = PTR_W'(idx);
            end
        end
    end

    // pointer moves past the winner only once the output takes it
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ptr_q <= '0;
        end else if (accept_i) begin
            if (win_idx == PTR_W'(maze_pkg::NUM_PORTS - 1)) begin
                ptr_q <= '0;
            end else begin
                ptr_q <= win_idx + 1'b1;
            end
        end
    end

    a_gnt_legal: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        $onehot0(gnt_o) && ((gnt_o & ~req_i) == '0)
    ) else $error("qos_arbiter: illegal grant");

endmodule

// ==== switch_alloc.sv ====
`timescale 1ns/1ps

module switch_alloc (
    input  logic                clk,
    input  logic                arst_n_i,
    input  maze_pkg::port_vec_t req_i     [maze_pkg::NUM_PORTS],  // per input
    input  maze_pkg::pkt_t      head_i    [maze_pkg::NUM_PORTS],
    input  maze_pkg::port_vec_t out_ready_i,                      // output slice ready
    output maze_pkg::port_vec_t out_valid_o,
    output maze_pkg::pkt_t      out_pkt_o [maze_pkg::NUM_PORTS],
    output maze_pkg::port_vec_t release_o
);

    maze_pkg::port_vec_t req_by_out [maze_pkg::NUM_PORTS];  // [out][in]
    maze_pkg::port_vec_t gnt_by_out [maze_pkg::NUM_PORTS];  // [out][in]
    maze_pkg::port_vec_t qos_vec;
    maze_pkg::port_vec_t accept;

    // ==============================
    // request transpose
    // ==============================
    always_comb begin
        for (int o = 0; o < maze_pkg::NUM_PORTS; o++) begin
            for (int i = 0; i < maze_pkg::NUM_PORTS; i++) begin
                req_by_out[o][i] = req_i[i][o];
            end
        end
    end

    // one qos vector serves every arbiter since req masks it
    always_comb begin
        for (int i = 0; i < maze_pkg::NUM_PORTS; i++) begin
            qos_vec[i] = head_i[i].qos;
        end
    end

    // ==============================
    // per-output arbiters
    // ==============================
    for (genvar o = 0; o < maze_pkg::NUM_PORTS; o++) begin : g_out
        qos_arbiter u_arb (
            .clk      (clk),
            .arst_n_i (arst_n_i),
            .req_i    (req_by_out[o]),
            .qos_i    (qos_vec),
            .accept_i (accept[o]),
            .gnt_o    (gnt_by_out[o])
        );
    end

    always_comb begin
        for (int o = 0; o < maze_pkg::NUM_PORTS; o++) begin
            out_valid_o[o] = |gnt_by_out[o];
            accept[o]      = out_valid_o[o] & out_ready_i[o];
        end
    end

    // crossbar
    always_comb begin
        for (int o = 0; o < maze_pkg::NUM_PORTS; o++) begin
            out_pkt_o[o] = '0;
            for (int i = 0; i < maze_pkg::NUM_PORTS; i++) begin
                if (gnt_by_out[o][i]) begin
                    out_pkt_o[o] = head_i[i];
                end
            end
        end
    end

    // grant taken by the output slice frees the input register
    always_comb begin
        release_o = '0;
        for (int i = 0; i < maze_pkg::NUM_PORTS; i++) begin
            for (int o = 0; o < maze_pkg::NUM_PORTS; o++) begin
                release_o[i] = release_o[i] | (gnt_by_out[o][i] & out_ready_i[o]);
            end
        end
    end

endmodule

// ==== maze_node.sv ====
`timescale 1ns/1ps

module maze_node #(
    parameter logic [maze_pkg::COORD_W-1:0] LOC_X = '0,
    parameter logic [maze_pkg::COORD_W-1:0] LOC_Y = '0
) (
    input  logic                clk,
    input  logic                arst_n_i,
    // fault configuration
    input  logic                pg_en_i,
    input  maze_pkg::coord_t    pg_node_i,
    // inputs indexed by port
    input  maze_pkg::port_vec_t in_valid_i,
    output maze_pkg::port_vec_t in_ready_o,
    input  maze_pkg::pkt_t      in_pkt_i  [maze_pkg::NUM_PORTS],
    // outputs indexed by port
    output maze_pkg::port_vec_t out_valid_o,
    input  maze_pkg::port_vec_t out_ready_i,
    output maze_pkg::pkt_t      out_pkt_o [maze_pkg::NUM_PORTS]
);

    maze_pkg::port_vec_t req      [maze_pkg::NUM_PORTS];
    maze_pkg::pkt_t      head     [maze_pkg::NUM_PORTS];
    maze_pkg::pkt_t      xbar_pkt [maze_pkg::NUM_PORTS];
    maze_pkg::port_vec_t xbar_valid;
    maze_pkg::port_vec_t obuf_ready;
    maze_pkg::port_vec_t rel_vec;   // input register release

    // ==============================
    // route and hold stage
    // ==============================
    for (genvar p = 0; p < maze_pkg::NUM_PORTS; p++) begin : g_in
        input_port #(
            .LOC_X (LOC_X),
            .LOC_Y (LOC_Y)
        ) u_in (
            .clk       (clk),
            .arst_n_i  (arst_n_i),
            .valid_i   (in_valid_i[p]),
            .ready_o   (in_ready_o[p]),
            .pkt_i     (in_pkt_i[p]),
            .pg_en_i   (pg_en_i),
            .pg_node_i (pg_node_i),
            .req_o     (req[p]),
            .head_o    (head[p]),
            .release_i (rel_vec[p])
        );
    end

    // allocation stage
    switch_alloc u_alloc (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .req_i       (req),
        .head_i      (head),
        .out_ready_i (obuf_ready),
        .out_valid_o (xbar_valid),
        .out_pkt_o   (xbar_pkt),
        .release_o   (rel_vec)
    );

    // output register stage
    for (genvar p = 0; p < maze_pkg::NUM_PORTS; p++) begin : g_out
        reg_slice #(
            .T (maze_pkg::pkt_t)
        ) u_obuf (
            .clk      (clk),
            .arst_n_i (arst_n_i),
            .valid_i  (xbar_valid[p]),
            .ready_o  (obuf_ready[p]),
            .data_i   (xbar_pkt[p]),
            .valid_o  (out_valid_o[p]),
            .ready_i  (out_ready_i[p]),
            .data_o   (out_pkt_o[p])
        );
    end

endmodule

// ==== tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter real PERIOD       = 100.0,
    parameter int  RESET_CYCLES = 10
) (
    output logic clk_o,
    output logic arst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD / 2.0) clk_o = ~clk_o;
    end

    // released just after a rising edge away from the sampling point
    initial begin
        arst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #1;
        arst_n_o = 1'b1;
    end

endmodule

// ==== maze_node_tb.sv ====
`timescale 1ns/1ps

module maze_node_tb;

    localparam int  NP          = maze_pkg::NUM_PORTS;
    localparam int  LOC_X       = 3;
    localparam int  LOC_Y       = 3;
    localparam real CLK_PERIOD  = 100.0;
    localparam int  N_ROUTE     = 30;   // per input
    localparam int  N_FAULT     = 16;   // per input and fault phase
    localparam int  N_BP        = 40;   // per input
    localparam int  TOTAL_PKTS  = NP * (N_ROUTE + 2 * N_FAULT + N_BP) + 7;
    localparam int  DRAIN_LIMIT = 200;  // cycles allowed for the queues to empty

    logic                clk;
    logic                arst_n_i;
    logic                pg_en_i;
    maze_pkg::coord_t    pg_node_i;
    maze_pkg::port_vec_t in_valid_i;
    maze_pkg::port_vec_t in_ready_o;
    maze_pkg::pkt_t      in_pkt_i [NP];
    maze_pkg::port_vec_t out_valid_o;
    maze_pkg::port_vec_t out_ready_i;
    maze_pkg::pkt_t      out_pkt_o [NP];

    maze_pkg::pkt_t      exp_q [NP*NP][$];  // [out*NP + in]
    maze_pkg::port_vec_t head_ok;           // output head matches the model
    logic [31:0]         lfsr_q = 32'hbab4_559c;
    logic                lat_arm;
    int                  lat_port;
    logic                qos_first;

    tb_clk_gen #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(10)) u_clk (
        .clk_o    (clk),
        .arst_n_o (arst_n_i)
    );

    maze_node #(.LOC_X(3'(LOC_X)), .LOC_Y(3'(LOC_Y))) i_dut (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .pg_en_i     (pg_en_i),
        .pg_node_i   (pg_node_i),
        .in_valid_i  (in_valid_i),
        .in_ready_o  (in_ready_o),
        .in_pkt_i    (in_pkt_i),
        .out_valid_o (out_valid_o),
        .out_ready_i (out_ready_i),
        .out_pkt_o   (out_pkt_o)
    );

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "run aborted");
    endtask

    task automatic report_mismatch(input string msg);
        $display("Fail %0t: %s", $time, msg);
        abort_run("wrong value seen at a node output");
    endtask

    // galois lfsr with one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
            r = {r[30:0], lfsr_q[0]};
        end
        return r;
    endfunction

    // ==============================
    // reference routing
    // ==============================
    function automatic int expected_port(input maze_pkg::coord_t tgt, input logic en,
                                         input maze_pkg::coord_t bad);
        int tx;
        int ty;
        int nx;
        int ny;
        int port;
        tx = int'(tgt.x);
        ty = int'(tgt.y);
        nx = LOC_X;
        ny = LOC_Y;
        if (tx == LOC_X && ty == LOC_Y) begin
            return maze_pkg::PORT_LOCAL;
        end
        if (tx != LOC_X) begin
            port = (tx > LOC_X) ? maze_pkg::PORT_EAST : maze_pkg::PORT_WEST;
            nx   = (tx > LOC_X) ? LOC_X + 1 : LOC_X - 1;
        end else begin
            port = (ty > LOC_Y) ? maze_pkg::PORT_NORTH : maze_pkg::PORT_SOUTH;
            ny   = (ty > LOC_Y) ? LOC_Y + 1 : LOC_Y - 1;
        end
        if (en && nx == int'(bad.x) && ny == int'(bad.y) && tgt != bad) begin
            if (port == maze_pkg::PORT_EAST || port == maze_pkg::PORT_WEST) begin
                if (ty != LOC_Y) begin
                    port = (ty > LOC_Y) ? maze_pkg::PORT_NORTH : maze_pkg::PORT_SOUTH;
                end else begin
                    port = (LOC_Y == maze_pkg::MESH_DIM - 1) ? maze_pkg::PORT_SOUTH
                                                             : maze_pkg::PORT_NORTH;
                end
            end else begin
                port = (LOC_X == maze_pkg::MESH_DIM - 1) ? maze_pkg::PORT_WEST
                                                         : maze_pkg::PORT_EAST;
            end
        end
        return port;
    endfunction

    function automatic int pending_count();
        int n;
        n = 0;
        for (int k = 0; k < NP * NP; k++) begin
            n += exp_q[k].size();
        end
        return n;
    endfunction

    // src.x carries the input index so the model can find the right queue
    function automatic maze_pkg::pkt_t make_pkt(input int p);
        maze_pkg::pkt_t pkt;
        pkt.qos   = 1'(rand_bits(1));
        pkt.ptype = 2'(rand_bits(2));
        pkt.src.x = 3'(p);
        pkt.src.y = 3'(rand_bits(3));
        pkt.tgt.x = 3'(rand_bits(3));
        pkt.tgt.y = 3'(rand_bits(3));
        pkt.data  = 8'(rand_bits(8));
        if (rand_bits(3) == 0) begin
            pkt.tgt = '{y: 3'(LOC_Y), x: 3'(LOC_X)};  // local delivery now and then
        end
        return pkt;
    endfunction

    // model sees the handshakes of the coming edge while inputs are stable
    always @(negedge clk) begin : model
        int src_idx;
        int q;
        for (int o = 0; o < NP; o++) begin
            head_ok[o] = 1'b0;
            src_idx    = int'(out_pkt_o[o].src.x);
            q          = o * NP + src_idx;
            if (arst_n_i && out_valid_o[o] && src_idx < NP) begin
                if (exp_q[q].size() > 0) begin
                    head_ok[o] = (exp_q[q][0] == out_pkt_o[o]);
                end
                if (head_ok[o] && out_ready_i[o]) begin
                    void'(exp_q[q].pop_front());
                end
            end
        end
        for (int p = 0; p < NP; p++) begin
            if (arst_n_i && in_valid_i[p] && in_ready_o[p]) begin
                q = expected_port(in_pkt_i[p].tgt, pg_en_i, pg_node_i) * NP + p;
                exp_q[q].push_back(in_pkt_i[p]);
            end
        end
    end

    // ==============================
    // checks
    // ==============================
    a_reset_idle: assert property (
        @(posedge clk) $rose(arst_n_i) |-> out_valid_o == '0 && in_ready_o == '1
    ) else report_mismatch("node not idle after reset");

    a_latency: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        lat_arm && (|(in_valid_i & in_ready_o))
            |-> ##1 !out_valid_o[lat_port] ##1 out_valid_o[lat_port]
    ) else report_mismatch($sformatf("packet not at port %0d after 2 cycles", lat_port));

    a_qos_first: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        qos_first && out_valid_o[maze_pkg::PORT_EAST] && out_ready_i[maze_pkg::PORT_EAST]
            |-> out_pkt_o[maze_pkg::PORT_EAST].qos
    ) else report_mismatch("low qos packet left before high qos packet");

    for (genvar o = 0; o < NP; o++) begin : g_chk
        a_out_match: assert property (
            @(posedge clk) disable iff (!arst_n_i)
            out_valid_o[o] && out_ready_i[o] |-> head_ok[o]
        ) else report_mismatch($sformatf("port %0d sent unexpected %h", o, out_pkt_o[o]));

        a_out_hold: assert property (
            @(posedge clk) disable iff (!arst_n_i)
            out_valid_o[o] && !out_ready_i[o] |=> out_valid_o[o] && $stable(out_pkt_o[o])
        ) else report_mismatch($sformatf("port %0d payload changed while stalled", o));
    end

    // ==============================
    // stimulus
    // ==============================
    task automatic send_one(input int p, input maze_pkg::pkt_t pkt);
        in_pkt_i[p]   = pkt;
        in_valid_i[p] = 1'b1;
        @(negedge clk);
        while (!in_ready_o[p]) @(negedge clk);
        @(posedge clk);
        #1;
        in_valid_i[p] = 1'b0;
    endtask

    task automatic send_to(input int p, input int x, input int y);
        maze_pkg::pkt_t pkt;
        pkt     = make_pkt(p);
        pkt.tgt = '{y: 3'(y), x: 3'(x)};
        send_one(p, pkt);
    endtask

    // leftovers after the bound stay queued for the final check
    task automatic drain();
        int waited;
        waited = 0;
        while (pending_count() != 0 && waited < DRAIN_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        repeat (3) @(posedge clk);
        #1;
    endtask

    // n packets per input with out_ready_i toggling randomly when bp is set
    task automatic run_traffic(input int n, input bit bp);
        int                  left [NP];
        maze_pkg::port_vec_t hs;
        bit                  busy;
        hs   = '0;
        busy = 1'b1;
        for (int p = 0; p < NP; p++) begin
            left[p] = n;
        end
        while (busy) begin
            busy = 1'b0;
            for (int p = 0; p < NP; p++) begin
                if (hs[p] || !in_valid_i[p]) begin
                    in_valid_i[p] = (left[p] > 0);
                    if (left[p] > 0) begin
                        in_pkt_i[p] = make_pkt(p);
                        left[p]--;
                    end
                end
                busy |= in_valid_i[p];
            end
            out_ready_i = bp ? 5'(rand_bits(NP)) : '1;
            if (busy) begin
                @(negedge clk);
                hs = in_valid_i & in_ready_o;
                @(posedge clk);
                #1;
            end
        end
        out_ready_i = '1;
        drain();
    endtask

    initial begin : main
        maze_pkg::pkt_t pkt_lo;
        maze_pkg::pkt_t pkt_hi;
        in_valid_i  = '0;
        out_ready_i = '1;
        pg_en_i     = 1'b0;
        pg_node_i   = '0;
        lat_arm     = 1'b0;
        lat_port    = 0;
        qos_first   = 1'b0;
        for (int p = 0; p < NP; p++) begin
            in_pkt_i[p] = '0;
        end
        wait (arst_n_i === 1'b1);
        @(posedge clk);
        #1;

        run_traffic(N_ROUTE, 1'b0);   // plain xy routing

        lat_port = maze_pkg::PORT_NORTH;
        lat_arm  = 1'b1;
        send_to(maze_pkg::PORT_WEST, 3, 6);
        drain();
        lat_arm  = 1'b0;

        // two packets meet at a stalled east output
        out_ready_i[maze_pkg::PORT_EAST] = 1'b0;
        pkt_lo     = make_pkt(maze_pkg::PORT_NORTH);
        pkt_lo.qos = 1'b0;
        pkt_lo.tgt = '{y: 3'd3, x: 3'd6};
        pkt_hi     = make_pkt(maze_pkg::PORT_SOUTH);
        pkt_hi.qos = 1'b1;
        pkt_hi.tgt = '{y: 3'd5, x: 3'd7};
        in_pkt_i[maze_pkg::PORT_NORTH]   = pkt_lo;
        in_pkt_i[maze_pkg::PORT_SOUTH]   = pkt_hi;
        in_valid_i[maze_pkg::PORT_NORTH] = 1'b1;
        in_valid_i[maze_pkg::PORT_SOUTH] = 1'b1;
        @(posedge clk);
        #1;
        in_valid_i = '0;
        repeat (4) @(posedge clk);
        #1;
        qos_first = 1'b1;
        out_ready_i[maze_pkg::PORT_EAST] = 1'b1;
        @(posedge clk);
        #1;
        qos_first = 1'b0;
        drain();

        // east neighbour faulty and then north neighbour
        pg_en_i   = 1'b1;
        pg_node_i = '{y: 3'd3, x: 3'd4};
        send_to(maze_pkg::PORT_LOCAL, 4, 3);   // goes straight to the faulty node
        send_to(maze_pkg::PORT_WEST, 6, 3);
        run_traffic(N_FAULT, 1'b0);
        pg_node_i = '{y: 3'd4, x: 3'd3};
        send_to(maze_pkg::PORT_LOCAL, 3, 4);
        send_to(maze_pkg::PORT_SOUTH, 3, 6);
        run_traffic(N_FAULT, 1'b0);
        pg_en_i   = 1'b0;

        run_traffic(N_BP, 1'b1);      // random back-pressure

        if (pending_count() != 0) begin
            abort_run("packets were left undelivered at the end of the run");
        end else begin
            $display("TEST PASSED");
            $finish;
        end
    end

    initial begin : watchdog
        #(TOTAL_PKTS * 40 * CLK_PERIOD);
        abort_run("timeout: the run took longer than the watchdog allows");
    end

endmodule

// ==== maze_node.f ====
maze_pkg.sv
reg_slice.sv
input_port.sv
qos_arbiter.sv
switch_alloc.sv
maze_node.sv
tb_clk_gen.sv
maze_node_tb.sv
